// File: common/shaper_pkg.sv
package shaper_pkg;

    // stream payload width in bits
    localparam int DATA_WIDTH = 64;

    // number of rate limited lanes behind the demux
    localparam int NUM_LANES = 4;

    // lane number carried on the destination field
    localparam int DEST_WIDTH = 2;

    // width of rate_num and rate_denom
    localparam int RATE_WIDTH = 8;

    // credit accumulator width, wide enough for long frames in by-frame mode
    localparam int ACC_WIDTH = 24;

    // rate after reset, 1 of 1 means no throttling
    localparam logic [RATE_WIDTH-1:0] RATE_NUM_RST   = 8'd1;
    localparam logic [RATE_WIDTH-1:0] RATE_DENOM_RST = 8'd1;

    // demux routing state
    // idle routes by s_tdest, frame routes by the latched lane
    typedef enum logic {
        DMX_IDLE,
        DMX_FRAME
    } demux_state_t;

    // arbiter grant state
    // idle picks a new lane, frame holds the grant until tlast
    typedef enum logic {
        ARB_IDLE,
        ARB_FRAME
    } arb_state_t;

endpackage

// File: common/axis_if.sv
interface axis_if
    import shaper_pkg::*;
();

    // payload
    logic [DATA_WIDTH-1:0] tdata;
    logic                  tlast;
    logic                  tuser;

    // handshake, a beat moves when both are high
    logic                  tvalid;
    logic                  tready;

    // upstream side drives payload and valid
    modport src (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    // downstream side only drives ready
    modport snk (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

// File: rtl/lane_demux.sv
module lane_demux
    import shaper_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic                  s_tvalid,
    input  logic                  s_tlast,
    input  logic                  s_tuser,
    input  logic [DEST_WIDTH-1:0] s_tdest,
    output logic                  s_tready,

    axis_if.src                   lanes [NUM_LANES]
);

    demux_state_t          state_reg;
    logic [DEST_WIDTH-1:0] lane_reg;
    logic [DEST_WIDTH-1:0] sel_lane;
    logic [NUM_LANES-1:0]  lane_ready;
    logic                  s_fire;

    // first beat routes by tdest, rest of the frame by the latched lane
    assign sel_lane = (state_reg == DMX_FRAME) ? lane_reg : s_tdest;

    // ready comes straight back from the chosen lane
    assign s_tready = lane_ready[sel_lane];
    assign s_fire   = s_tvalid & s_tready;

    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_lane
            // payload fans out to every lane, only valid is steered
            assign lanes[i].tdata  = s_tdata;
            assign lanes[i].tlast  = s_tlast;
            assign lanes[i].tuser  = s_tuser;
            assign lanes[i].tvalid = s_tvalid & (sel_lane == DEST_WIDTH'(i));
            assign lane_ready[i]   = lanes[i].tready;
        end
    endgenerate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg <= DMX_IDLE;
            lane_reg  <= '0;
        end else if (s_fire) begin
            if (s_tlast) begin
                // frame done, next beat may go anywhere
                state_reg <= DMX_IDLE;
            end else begin
                // lock the lane until tlast passes
                state_reg <= DMX_FRAME;
                lane_reg  <= sel_lane;
            end
        end
    end

endmodule

// File: rate_limit/axis_rate_limit.sv
module axis_rate_limit
    import shaper_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst,

    // config strobe, taken when cfg_lane matches this lane
    input  logic                  cfg_wr,
    input  logic [DEST_WIDTH-1:0] cfg_lane,
    input  logic [RATE_WIDTH-1:0] cfg_num,
    input  logic [RATE_WIDTH-1:0] cfg_denom,
    input  logic                  cfg_by_frame,

    axis_if.snk                   in_s,
    axis_if.src                   out_m
);

    // rate configuration
    logic [RATE_WIDTH-1:0] rate_num_reg;
    logic [RATE_WIDTH-1:0] rate_denom_reg;
    logic                  by_frame_reg;
    logic                  cfg_hit;

    // credit tracking
    logic [ACC_WIDTH-1:0]  acc_reg;
    logic [ACC_WIDTH-1:0]  acc_next;
    logic                  frame_reg;
    logic                  frame_next;
    logic                  pause;

    // input side handshake
    logic                  in_ready_reg;
    logic                  stage_ready_reg;
    logic                  ready_early;
    logic                  accept;

    // main output register and skid register
    logic                  out_valid_reg;
    logic [DATA_WIDTH-1:0] out_data_reg;
    logic                  out_last_reg;
    logic                  out_user_reg;
    logic                  tmp_valid_reg;
    logic [DATA_WIDTH-1:0] tmp_data_reg;
    logic                  tmp_last_reg;
    logic                  tmp_user_reg;
    logic                  out_valid_next;
    logic                  tmp_valid_next;
    logic                  load_in_out;
    logic                  load_in_tmp;
    logic                  load_tmp_out;

    assign cfg_hit = cfg_wr & (cfg_lane == DEST_WIDTH'(LANE_ID));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rate_num_reg   <= RATE_NUM_RST;
            rate_denom_reg <= RATE_DENOM_RST;
            by_frame_reg   <= 1'b0;
        end else if (cfg_hit) begin
            rate_num_reg   <= cfg_num;
            rate_denom_reg <= cfg_denom;
            by_frame_reg   <= cfg_by_frame;
        end
    end

    assign in_s.tready = in_ready_reg;
    assign accept      = in_s.tvalid & in_ready_reg;

    always_comb begin
        acc_next   = acc_reg;
        frame_next = frame_reg;
        pause      = 1'b0;
        // pay off one slice of credit per cycle when there is enough
        if (acc_reg >= ACC_WIDTH'(rate_num_reg)) begin
            acc_next = acc_reg - ACC_WIDTH'(rate_num_reg);
        end
        // each beat costs denom minus num
        if (accept) begin
            frame_next = ~in_s.tlast;
            acc_next   = acc_reg + ACC_WIDTH'(rate_denom_reg) - ACC_WIDTH'(rate_num_reg);
        end
        // over budget, stop now or at the next frame boundary
        if (acc_next >= ACC_WIDTH'(rate_num_reg)) begin
            pause = by_frame_reg ? ~frame_next : 1'b1;
        end
    end

    // room for another beat next cycle
    // either the sink takes one, or neither register will be full
    assign ready_early = out_m.tready | (~tmp_valid_reg & (~out_valid_reg | ~accept));

    always_comb begin
        out_valid_next = out_valid_reg;
        tmp_valid_next = tmp_valid_reg;
        load_in_out    = 1'b0;
        load_in_tmp    = 1'b0;
        load_tmp_out   = 1'b0;
        if (stage_ready_reg) begin
            if (out_m.tready | ~out_valid_reg) begin
                // output free, beat goes straight through
                out_valid_next = accept;
                load_in_out    = 1'b1;
            end else begin
                // output stalled, park the beat in the skid register
                tmp_valid_next = accept;
                load_in_tmp    = 1'b1;
            end
        end else if (out_m.tready) begin
            // drain the skid register
            out_valid_next = tmp_valid_reg;
            tmp_valid_next = 1'b0;
            load_tmp_out   = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_reg         <= '0;
            frame_reg       <= 1'b0;
            in_ready_reg    <= 1'b0;
            stage_ready_reg <= 1'b0;
            out_valid_reg   <= 1'b0;
            tmp_valid_reg   <= 1'b0;
        end else begin
            acc_reg         <= acc_next;
            frame_reg       <= frame_next;
            in_ready_reg    <= ready_early & ~pause;
            stage_ready_reg <= ready_early;
            out_valid_reg   <= out_valid_next;
            tmp_valid_reg   <= tmp_valid_next;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (load_in_out) begin
            out_data_reg <= in_s.tdata;
            out_last_reg <= in_s.tlast;
            out_user_reg <= in_s.tuser;
        end else if (load_tmp_out) begin
            out_data_reg <= tmp_data_reg;
            out_last_reg <= tmp_last_reg;
            out_user_reg <= tmp_user_reg;
        end
        if (load_in_tmp) begin
            tmp_data_reg <= in_s.tdata;
            tmp_last_reg <= in_s.tlast;
            tmp_user_reg <= in_s.tuser;
        end
    end

    assign out_m.tvalid = out_valid_reg;
    assign out_m.tdata  = out_data_reg;
    assign out_m.tlast  = out_last_reg;
    assign out_m.tuser  = out_user_reg;

endmodule

// File: rtl/lane_arbiter.sv
module lane_arbiter
    import shaper_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    axis_if.snk                   lanes [NUM_LANES],

    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tvalid,
    output logic                  m_tlast,
    output logic                  m_tuser,
    output logic [DEST_WIDTH-1:0] m_tdest,
    input  logic                  m_tready
);

    arb_state_t            state_reg;
    // current grant in a frame, last grant when idle
    logic [DEST_WIDTH-1:0] grant_reg;

    logic [NUM_LANES-1:0]  lane_valid;
    logic [NUM_LANES-1:0]  lane_last;
    logic [NUM_LANES-1:0]  lane_user;
    logic [DATA_WIDTH-1:0] lane_data [NUM_LANES];
    logic [NUM_LANES-1:0]  lane_ready;

    logic [DEST_WIDTH-1:0] rr_lane;
    logic [DEST_WIDTH-1:0] rr_cand;
    logic                  rr_found;
    logic [DEST_WIDTH-1:0] sel_lane;
    logic                  sel_valid;
    logic                  out_ready;
    logic                  take;

    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_lane
            assign lane_valid[i]  = lanes[i].tvalid;
            assign lane_last[i]   = lanes[i].tlast;
            assign lane_user[i]   = lanes[i].tuser;
            assign lane_data[i]   = lanes[i].tdata;
            assign lanes[i].tready = lane_ready[i];
            // only the selected lane sees ready, and only when a beat moves
            assign lane_ready[i]  = take & (sel_lane == DEST_WIDTH'(i));
        end
    endgenerate

    // round robin, search starts one past the last grant
    always_comb begin
        rr_lane  = grant_reg;
        rr_found = 1'b0;
        rr_cand  = grant_reg;
        for (int k = 1; k <= NUM_LANES; k++) begin
            rr_cand = grant_reg + DEST_WIDTH'(k);
            if (!rr_found && lane_valid[rr_cand]) begin
                rr_lane  = rr_cand;
                rr_found = 1'b1;
            end
        end
    end

    assign sel_lane  = (state_reg == ARB_FRAME) ? grant_reg : rr_lane;
    assign sel_valid = (state_reg == ARB_FRAME) ? lane_valid[grant_reg] : rr_found;

    // output register takes a beat when empty or being drained
    assign out_ready = m_tready | ~m_tvalid;
    assign take      = sel_valid & out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg <= ARB_IDLE;
            grant_reg <= '0;
            m_tvalid  <= 1'b0;
        end else begin
            if (out_ready) begin
                m_tvalid <= sel_valid;
            end
            if (take) begin
                grant_reg <= sel_lane;
                // hold the grant until the frame's last beat moves
                state_reg <= lane_last[sel_lane] ? ARB_IDLE : ARB_FRAME;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_tdata <= lane_data[sel_lane];
            m_tlast <= lane_last[sel_lane];
            m_tuser <= lane_user[sel_lane];
            m_tdest <= sel_lane;
        end
    end

endmodule

// File: rtl/traffic_shaper_top.sv
module traffic_shaper_top
    import shaper_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // input stream, tdest picks the lane
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  logic                  s_tlast,
    input  logic                  s_tuser,
    input  logic [DEST_WIDTH-1:0] s_tdest,

    // per lane rate config
    input  logic                  cfg_wr,
    input  logic [DEST_WIDTH-1:0] cfg_lane,
    input  logic [RATE_WIDTH-1:0] cfg_num,
    input  logic [RATE_WIDTH-1:0] cfg_denom,
    input  logic                  cfg_by_frame,

    // merged output stream, tdest reports the source lane
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output logic                  m_tlast,
    output logic                  m_tuser,
    output logic [DEST_WIDTH-1:0] m_tdest
);

    axis_if demux_to_lane [NUM_LANES] ();
    axis_if lane_to_arb   [NUM_LANES] ();

    lane_demux u_demux (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .s_tdest  (s_tdest),
        .s_tready (s_tready),
        .lanes    (demux_to_lane)
    );

    // one limiter per lane, each matches its own index on cfg_lane
    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g++) begin : g_limit
            axis_rate_limit #(
                .LANE_ID (g)
            ) u_limit (
                .clk          (clk),
                .rst          (rst),
                .cfg_wr       (cfg_wr),
                .cfg_lane     (cfg_lane),
                .cfg_num      (cfg_num),
                .cfg_denom    (cfg_denom),
                .cfg_by_frame (cfg_by_frame),
                .in_s         (demux_to_lane[g]),
                .out_m        (lane_to_arb[g])
            );
        end
    endgenerate

    lane_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .lanes    (lane_to_arb),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tdest  (m_tdest),
        .m_tready (m_tready)
    );

endmodule

// File: sim/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: sim/traffic_shaper_asserts.sv
module traffic_shaper_asserts
    import shaper_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  s_tvalid,
    input logic                  s_tready,
    input logic                  s_tlast,
    input logic [DEST_WIDTH-1:0] s_tdest,
    input logic [DATA_WIDTH-1:0] m_tdata,
    input logic                  m_tvalid,
    input logic                  m_tready,
    input logic                  m_tlast,
    input logic                  m_tuser,
    input logic [DEST_WIDTH-1:0] m_tdest
);

    timeunit 1ns;
    timeprecision 1ps;

    logic                  s_in_frame;
    logic [DEST_WIDTH-1:0] s_dest_lat;
    logic                  m_in_frame;
    logic [DEST_WIDTH-1:0] m_dest_lat;

    // frame tracking on both stream ports
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_in_frame <= 1'b0;
            s_dest_lat <= '0;
            m_in_frame <= 1'b0;
            m_dest_lat <= '0;
        end else begin
            if (s_tvalid && s_tready) begin
                s_in_frame <= ~s_tlast;
                s_dest_lat <= s_tdest;
            end
            if (m_tvalid && m_tready) begin
                m_in_frame <= ~m_tlast;
                m_dest_lat <= m_tdest;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |-> !m_tvalid)
        else $error("m_tvalid high during reset");

    // output beat held until taken
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast)
            && $stable(m_tuser) && $stable(m_tdest)))
        else $error("output beat changed while stalled");

    a_in_dest: assert property (@(posedge clk) disable iff (rst)
        (s_in_frame && s_tvalid) |-> (s_tdest == s_dest_lat))
        else $error("s_tdest changed inside a frame");

    a_out_dest: assert property (@(posedge clk) disable iff (rst)
        (m_in_frame && m_tvalid) |-> (m_tdest == m_dest_lat))
        else $error("m_tdest changed inside a frame");

endmodule

// File: sim/traffic_shaper_tb.sv
module traffic_shaper_tb
    import shaper_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    bind traffic_shaper_top traffic_shaper_asserts u_asserts (
        .clk(clk), .rst(rst), .s_tvalid(s_tvalid), .s_tready(s_tready),
        .s_tlast(s_tlast), .s_tdest(s_tdest), .m_tdata(m_tdata), .m_tvalid(m_tvalid),
        .m_tready(m_tready), .m_tlast(m_tlast), .m_tuser(m_tuser), .m_tdest(m_tdest)
    );

    // one row of stimulus
    typedef struct {
        int lane;
        int len;
        int frames;
        int num;
        int denom;
        bit by_frame;
        bit spread;
        bit rnd_ready;
        int rate_chk;
        bit lane_wait;
        bit drain;
    } entry_t;

    logic                  clk;
    logic                  rst;
    logic [DATA_WIDTH-1:0] s_tdata;
    logic                  s_tvalid;
    logic                  s_tready;
    logic                  s_tlast;
    logic                  s_tuser;
    logic [DEST_WIDTH-1:0] s_tdest;
    logic                  cfg_wr;
    logic [DEST_WIDTH-1:0] cfg_lane;
    logic [RATE_WIDTH-1:0] cfg_num;
    logic [RATE_WIDTH-1:0] cfg_denom;
    logic                  cfg_by_frame;
    logic [DATA_WIDTH-1:0] m_tdata;
    logic                  m_tvalid;
    logic                  m_tready;
    logic                  m_tlast;
    logic                  m_tuser;
    logic [DEST_WIDTH-1:0] m_tdest;

    integer      seed = 21482;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    int          frame_id = 0;
    bit          rnd_mode = 1'b0;
    bit          out_in_frame = 1'b0;
    int          out_dest = 0;
    entry_t      table_q[$];
    // scoreboard holds {tuser, tlast, tdata} per lane
    logic [65:0] exp_q[NUM_LANES][$];
    // input accept cycles of the entry under test
    int          acc_times[$];
    int          frame_first[$];
    int          frame_last[$];

    clk_gen u_clk (.clk(clk), .rst(rst));

    traffic_shaper_top DUT (.*);

    task automatic report_error(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input int lane, input int len, input int frames, input int num,
                             input int denom, input bit by_frame, input bit spread,
                             input bit rnd_ready, input int rate_chk, input bit lane_wait,
                             input bit drain);
        entry_t e;
        e = '{lane, len, frames, num, denom, by_frame, spread, rnd_ready, rate_chk,
              lane_wait, drain};
        table_q.push_back(e);
    endtask

    // pulses the config strobe for one cycle starting 1 ns after a rising edge
    task automatic write_config(input int lane, input int num, input int denom,
                                input bit by_frame);
        cfg_wr       = 1'b1;
        cfg_lane     = DEST_WIDTH'(lane);
        cfg_num      = RATE_WIDTH'(num);
        cfg_denom    = RATE_WIDTH'(denom);
        cfg_by_frame = by_frame;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic send_frame(input int lane, input int len);
        logic [DATA_WIDTH-1:0] data;
        int                    cnt;
        frame_first.push_back(acc_times.size());
        for (int b = 0; b < len; b++) begin
            // lane, frame number and beat index
            data     = DATA_WIDTH'({8'(lane), 16'(frame_id), 16'(b)});
            s_tdata  = data;
            s_tvalid = 1'b1;
            s_tlast  = (b == len - 1);
            s_tuser  = (b == 0);
            s_tdest  = DEST_WIDTH'(lane);
            cnt      = 0;
            do begin
                @(negedge clk);
                cnt++;
                if (cnt > 2000) begin
                    report_error("input beat was never accepted by the DUT");
                end
            end while (!s_tready);
            acc_times.push_back(cycle_cnt);
            exp_q[lane].push_back({s_tuser, s_tlast, data});
            @(posedge clk);
            #1;
        end
        frame_last.push_back(acc_times.size() - 1);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        frame_id++;
    endtask

    task automatic wait_lane_empty(input int lane, input int limit);
        int cnt;
        cnt = 0;
        while (exp_q[lane].size() != 0) begin
            @(negedge clk);
            cnt++;
            if (cnt > limit) begin
                report_error("beats of a lane were not delivered before the timeout");
            end
        end
    endtask

    task automatic wait_all_empty(input int limit);
        int cnt;
        int left;
        cnt = 0;
        do begin
            left = 0;
            for (int l = 0; l < NUM_LANES; l++) begin
                left += exp_q[l].size();
            end
            if (left != 0) begin
                @(negedge clk);
                cnt++;
                if (cnt > limit) begin
                    report_error("the output did not drain before the timeout");
                end
            end
        end while (left != 0);
    endtask

    // at most W/4 + 2 accepted beats in any W cycle window
    task automatic check_rate(input bit whole_frames);
        int w;
        int n;
        if (!whole_frames) begin
            for (int i = 0; i < acc_times.size(); i++) begin
                for (int j = i + 1; j < acc_times.size(); j++) begin
                    w = acc_times[j] - acc_times[i] + 1;
                    n = j - i + 1;
                    if (4 * n > w + 8) begin
                        report_error("per-beat rate limit exceeded in a window");
                    end
                end
            end
        end else begin
            // windows span from one frame start to a later frame end
            for (int i = 0; i < frame_first.size(); i++) begin
                for (int j = i + 1; j < frame_last.size(); j++) begin
                    w = acc_times[frame_last[j]] - acc_times[frame_first[i]] + 1;
                    n = frame_last[j] - frame_first[i] + 1;
                    if (4 * n > w + 8) begin
                        report_error("by-frame rate limit exceeded over whole frames");
                    end
                end
            end
            // no pause inside a frame
            for (int f = 0; f < frame_first.size(); f++) begin
                for (int k = frame_first[f]; k < frame_last[f]; k++) begin
                    if (acc_times[k + 1] != acc_times[k] + 1) begin
                        report_error("a by-frame lane paused inside a frame");
                    end
                end
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycle_cnt++;
        end
    end

    // output ready changes 1 ns after each rising edge
    initial begin
        logic [31:0] r;
        m_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            r = $random(seed);
            m_tready = rnd_mode ? r[0] : 1'b1;
        end
    end

    // output monitor and scoreboard
    initial begin
        logic [65:0] e;
        int          lane;
        forever begin
            @(negedge clk);
            if (!rst && m_tvalid && m_tready) begin
                lane = int'(m_tdest);
                if (exp_q[lane].size() == 0) begin
                    report_error("an output beat arrived that was never sent");
                end
                e = exp_q[lane].pop_front();
                check_value("m_tdata", m_tdata, e[63:0]);
                check_value("m_tlast", 64'(m_tlast), 64'(e[64]));
                check_value("m_tuser", 64'(m_tuser), 64'(e[65]));
                // frame atomicity on the merged stream
                if (out_in_frame) begin
                    check_value("m_tdest", 64'(m_tdest), 64'(out_dest));
                end
                out_dest     = lane;
                out_in_frame = !m_tlast;
            end
        end
    end

    initial begin
        entry_t e;
        int     cnt;
        int     lane;
        s_tdata      = '0;
        s_tvalid     = 1'b0;
        s_tlast      = 1'b0;
        s_tuser      = 1'b0;
        s_tdest      = '0;
        cfg_wr       = 1'b0;
        cfg_lane     = '0;
        cfg_num      = '0;
        cfg_denom    = '0;
        cfg_by_frame = 1'b0;

        // reset and the first cycle after it
        cnt = 0;
        do begin
            @(negedge clk);
            check_value("m_tvalid", 64'(m_tvalid), 64'd0);
            check_value("s_tready", 64'(s_tready), 64'd0);
            cnt++;
            if (cnt > 20) begin
                report_error("reset was never released");
            end
        end while (rst);
        @(posedge clk);
        #1;

        // lane len frames num denom by_frame spread rnd rate_chk lane_wait drain
        add_entry(0, 5, 12, 1, 1, 0, 1, 1, 0, 0, 1);
        add_entry(1, 32, 1, 1, 4, 0, 0, 0, 1, 0, 1);
        add_entry(2, 4, 5, 1, 8, 1, 0, 0, 2, 0, 1);
        add_entry(0, 3, 2, 1, 8, 0, 0, 1, 0, 0, 0);
        add_entry(3, 6, 6, 1, 1, 0, 0, 1, 0, 1, 1);
        add_entry(0, 2, 8, 1, 1, 0, 1, 1, 0, 0, 1);

        foreach (table_q[i]) begin
            e        = table_q[i];
            rnd_mode = e.rnd_ready;
            if (e.spread) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    write_config(l, e.num, e.denom, e.by_frame);
                end
            end else begin
                write_config(e.lane, e.num, e.denom, e.by_frame);
            end
            acc_times.delete();
            frame_first.delete();
            frame_last.delete();
            for (int f = 0; f < e.frames; f++) begin
                lane = e.spread ? (f % NUM_LANES) : e.lane;
                send_frame(lane, e.len);
            end
            if (e.lane_wait) begin
                wait_lane_empty(e.lane, e.frames * e.len * 6 + 64);
            end
            if (e.drain) begin
                wait_all_empty(e.frames * e.len * (e.denom / e.num) * 3 + 200);
            end
            if (e.rate_chk != 0) begin
                check_rate(e.rate_chk == 2);
            end
        end

        @(posedge clk);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: traffic_shaper.f
common/shaper_pkg.sv
common/axis_if.sv
rtl/lane_demux.sv
rate_limit/axis_rate_limit.sv
rtl/lane_arbiter.sv
rtl/traffic_shaper_top.sv
sim/clk_gen.sv
sim/traffic_shaper_asserts.sv
sim/traffic_shaper_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the traffic shaper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module traffic_shaper_tb \
    -Mdir obj_dir -o traffic_shaper_sim \
    -f traffic_shaper.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/traffic_shaper_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
